//--- hw/icache_pkg.sv
/*
 * shared types, fsm state encodings and constants of the instruction cache
 */
`default_nettype none

package icache_pkg;

    // ========================================
    // widths with a meaning
    // ========================================
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [63:0] beat_t;
    typedef logic [1:0]  resp_t;

    // byte offset inside one 8-byte block
    localparam int OFFSET_BITS = 3;

    localparam resp_t RESP_OKAY = 2'b00;

    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

    // ========================================
    // fsm states
    // ========================================
    typedef enum logic [1:0] {
        RS_IDLE,
        RS_REQUEST,
        RS_WAIT_DATA
    } refill_state_e;

    typedef enum logic [0:0] {
        HS_IDLE,
        HS_HIT
    } hit_state_e;

endpackage

`default_nettype wire

//--- hw/icache_tag_store.sv
/*
 * tag, valid and victim arrays of the two-way cache
 * combinational hit compare and the refill update
 */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store #(
    parameter int SET_BITS = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  icache_pkg::addr_t lookup_addr,
    input  logic              fill,
    output logic              hit,
    output logic              hit_way,
    output logic              victim_way
);
    import icache_pkg::*;

    localparam int TAG_BITS = 32 - SET_BITS - OFFSET_BITS;
    localparam int SETS     = 1 << SET_BITS;

    // ========================================
    // storage
    // ========================================
    logic [TAG_BITS-1:0] tag_q [2][SETS];
    logic [SETS-1:0]     valid_q [2];
    // way to replace next, one bit per set
    logic [SETS-1:0]     victim_q;

    logic [SET_BITS-1:0] set_idx;
    logic [TAG_BITS-1:0] addr_tag;
    logic [1:0]          way_hit;

    assign set_idx  = lookup_addr[OFFSET_BITS +: SET_BITS];
    assign addr_tag = lookup_addr[OFFSET_BITS + SET_BITS +: TAG_BITS];

    // ========================================
    // lookup
    // ========================================
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][set_idx] && (tag_q[w][set_idx] == addr_tag);
        end
    end

    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];
    assign victim_way = victim_q[set_idx];

    // ========================================
    // refill update
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                tag_q[0][s] <= '0;
                tag_q[1][s] <= '0;
            end
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            victim_q   <= '0;
        end else if (fill) begin
            // new block goes to the victim way, then the other way is next
            tag_q[victim_way][set_idx]   <= addr_tag;
            valid_q[victim_way][set_idx] <= 1'b1;
            victim_q[set_idx]            <= ~victim_q[set_idx];
        end
    end

    // a refill only writes the victim way, so one block is never cached twice
    a_single_way_hit : assert property (
        @(posedge clk) disable iff (rst) !(way_hit[0] && way_hit[1])
    ) else $error("tag store: both ways hit for one address");

endmodule

`default_nettype wire

//--- hw/icache_data_store.sv
/*
 * two-way data array with registered read and instruction half select
 */
`timescale 1ns/1ps
`default_nettype none

module icache_data_store #(
    parameter int SET_BITS = 8
) (
    input  logic              clk,
    input  icache_pkg::addr_t lookup_addr,
    input  logic              rd_en,
    input  logic              rd_way,
    input  logic              fill,
    input  logic              fill_way,
    input  icache_pkg::beat_t fill_data,
    output icache_pkg::inst_t rd_inst
);
    import icache_pkg::*;

    localparam int SETS = 1 << SET_BITS;

    beat_t mem [2][SETS];

    logic [SET_BITS-1:0] set_idx;
    logic [SET_BITS-1:0] rd_set_q;
    logic                rd_way_q;
    logic                rd_hi_q;
    beat_t               rd_beat;

    assign set_idx = lookup_addr[OFFSET_BITS +: SET_BITS];

    // block write on the accepted beat
    always_ff @(posedge clk) begin
        if (fill) begin
            mem[fill_way][set_idx] <= fill_data;
        end
    end

    // ========================================
    // read side
    // ========================================
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_set_q <= set_idx;
            rd_way_q <= rd_way;
            rd_hi_q  <= lookup_addr[OFFSET_BITS-1];
        end
    end

    assign rd_beat = mem[rd_way_q][rd_set_q];

    // bit 2 picks the upper instruction
    assign rd_inst = rd_hi_q ? rd_beat[63:32] : rd_beat[31:0];

endmodule

`default_nettype wire

//--- hw/icache_refill.sv
/*
 * miss fsm, read address channel and read beat capture
 */
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              flush,
    input  logic              hit,
    input  icache_pkg::addr_t pc,
    input  logic              arready,
    input  logic              rvalid,
    input  icache_pkg::beat_t rdata,
    input  icache_pkg::resp_t rresp,
    output logic              arvalid,
    output logic              rready,
    output icache_pkg::addr_t araddr,
    output icache_pkg::addr_t lookup_addr,
    output logic              refill_busy,
    output logic              fill,
    output icache_pkg::beat_t fill_data,
    output icache_pkg::inst_t refill_inst,
    output logic              refill_err
);
    import icache_pkg::*;

    refill_state_e state_q;
    refill_state_e state_d;
    logic          inst_hi_q;
    logic          flush_now;
    logic          req_start;

    // flush only counts when the pipeline is not stalled
    assign flush_now = flush && !stall;

    // ========================================
    // state machine
    // ========================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            RS_IDLE: begin
                if (!stall && !hit) begin
                    state_d = RS_REQUEST;
                end
            end
            RS_REQUEST: begin
                if (arvalid && arready) begin
                    state_d = RS_WAIT_DATA;
                end
            end
            RS_WAIT_DATA: begin
                if (rvalid && rready) begin
                    state_d = RS_IDLE;
                end
            end
            default: state_d = RS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush_now) begin
            state_q <= RS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign req_start = (state_q == RS_IDLE) && (state_d == RS_REQUEST) && !flush_now;

    // block aligned request address
    always_ff @(posedge clk) begin
        if (req_start) begin
            araddr    <= {pc[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
            inst_hi_q <= pc[OFFSET_BITS-1];
        end
    end

    // ========================================
    // bus and fill outputs
    // ========================================
    assign arvalid     = (state_q == RS_REQUEST);
    assign rready      = (state_q == RS_WAIT_DATA);
    assign refill_busy = (state_q != RS_IDLE);
    assign lookup_addr = (state_q == RS_IDLE) ? pc : araddr;

    assign fill        = rvalid && rready;
    assign fill_data   = rdata;
    assign refill_inst = inst_hi_q ? rdata[63:32] : rdata[31:0];
    assign refill_err  = (rresp != RESP_OKAY);

    a_araddr_held : assert property (
        @(posedge clk) disable iff (rst) arvalid && !arready |=> $stable(araddr)
    ) else $error("refill: araddr changed while the request was pending");

endmodule

`default_nettype wire

//--- hw/icache_fetch_out.sv
/*
 * hit fsm, output instruction register, inst_valid and the error flag
 */
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_out (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              flush,
    input  logic              hit,
    input  logic              hit_way,
    input  logic              refill_busy,
    input  logic              fill,
    input  logic              refill_err,
    input  icache_pkg::inst_t refill_inst,
    input  icache_pkg::inst_t rd_inst,
    output logic              rd_en,
    output logic              rd_way,
    output icache_pkg::inst_t inst,
    output logic              inst_valid,
    output logic              error
);
    import icache_pkg::*;

    hit_state_e state_q;
    logic       busy_q;
    logic       flush_now;
    logic       miss_start;

    assign flush_now = flush && !stall;

    // a hit starts only when no refill owns the lookup address
    assign rd_en  = (state_q == HS_IDLE) && !stall && hit && !refill_busy;
    assign rd_way = hit_way;

    // rising edge of refill_busy
    assign miss_start = refill_busy && !busy_q;

    // ========================================
    // hit state machine
    // ========================================
    always_ff @(posedge clk) begin
        if (rst || flush_now) begin
            state_q <= HS_IDLE;
        end else begin
            case (state_q)
                HS_IDLE: begin
                    if (rd_en) begin
                        state_q <= HS_HIT;
                    end
                end
                default: state_q <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= refill_busy;
        end
    end

    // ========================================
    // output to the decode stage
    // ========================================
    always_ff @(posedge clk) begin
        if (rst || flush_now) begin
            inst       <= NOP_INST;
            inst_valid <= 1'b1;
        end else if (fill) begin
            inst       <= refill_inst;
            inst_valid <= 1'b1;
        end else if (state_q == HS_HIT) begin
            // data store output is valid now
            inst       <= rd_inst;
            inst_valid <= 1'b1;
        end else if (rd_en || miss_start) begin
            inst_valid <= 1'b0;
        end
    end

    // flush leaves the error flag alone
    always_ff @(posedge clk) begin
        if (rst) begin
            error <= 1'b0;
        end else if (fill) begin
            error <= refill_err;
        end
    end

    // the refill fsm stays idle through the data store read slot
    a_no_refill_in_hit : assert property (
        @(posedge clk) disable iff (rst) rd_en |=> !refill_busy
    ) else $error("fetch out: refill started during a hit read");

endmodule

`default_nettype wire

//--- hw/icache_top.sv
/*
 * instruction cache top level
 * refill fsm, tag store, data store and output stage
 */
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int SET_BITS = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  icache_pkg::addr_t pc,
    input  logic              stall,
    input  logic              flush,
    output logic              arvalid,
    output icache_pkg::addr_t araddr,
    input  logic              arready,
    input  logic              rvalid,
    output logic              rready,
    input  icache_pkg::beat_t rdata,
    input  icache_pkg::resp_t rresp,
    output icache_pkg::inst_t inst,
    output logic              inst_valid,
    output logic              error
);
    import icache_pkg::*;

    addr_t lookup_addr;
    logic  hit;
    logic  hit_way;
    logic  victim_way;
    logic  refill_busy;
    logic  fill;
    beat_t fill_data;
    inst_t refill_inst;
    logic  refill_err;
    logic  rd_en;
    logic  rd_way;
    inst_t rd_inst;

    // ========================================
    // lookup side
    // ========================================
    icache_refill u_refill (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .hit         (hit),
        .pc          (pc),
        .arready     (arready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp),
        .arvalid     (arvalid),
        .rready      (rready),
        .araddr      (araddr),
        .lookup_addr (lookup_addr),
        .refill_busy (refill_busy),
        .fill        (fill),
        .fill_data   (fill_data),
        .refill_inst (refill_inst),
        .refill_err  (refill_err)
    );

    // ========================================
    // storage
    // ========================================
    icache_tag_store #(
        .SET_BITS (SET_BITS)
    ) u_tag_store (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .fill        (fill),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way)
    );

    icache_data_store #(
        .SET_BITS (SET_BITS)
    ) u_data_store (
        .clk         (clk),
        .lookup_addr (lookup_addr),
        .rd_en       (rd_en),
        .rd_way      (rd_way),
        .fill        (fill),
        .fill_way    (victim_way),
        .fill_data   (fill_data),
        .rd_inst     (rd_inst)
    );

    // ========================================
    // output side
    // ========================================
    icache_fetch_out u_fetch_out (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .hit         (hit),
        .hit_way     (hit_way),
        .refill_busy (refill_busy),
        .fill        (fill),
        .refill_err  (refill_err),
        .refill_inst (refill_inst),
        .rd_inst     (rd_inst),
        .rd_en       (rd_en),
        .rd_way      (rd_way),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .error       (error)
    );

endmodule

`default_nettype wire

//--- tb/axi_mem_model.sv
/*
 * read-only bus memory model with random handshake delays
 * rule-based block data, one address answers with an error response
 */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
    parameter icache_pkg::addr_t ERR_ADDR = 32'h0000_3000,
    parameter int                SEED     = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              arvalid,
    input  icache_pkg::addr_t araddr,
    output logic              arready,
    output logic              rvalid,
    input  logic              rready,
    output icache_pkg::beat_t rdata,
    output icache_pkg::resp_t rresp
);
    import icache_pkg::*;

    integer seed;
    int     delay;
    logic   data_phase;
    addr_t  addr_q;

    initial seed = SEED;

    // low word is the address xor a pattern, high word its inverse
    function automatic beat_t block_beat(input addr_t addr);
        inst_t lo;
        lo = addr ^ 32'h5A5A_5A5A;
        return {~lo, lo};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rdata      <= '0;
            rresp      <= RESP_OKAY;
            data_phase <= 1'b0;
            delay      <= 0;
        end else if (!data_phase) begin
            if (arvalid && arready) begin
                addr_q     <= araddr;
                arready    <= 1'b0;
                data_phase <= 1'b1;
                delay      <= $random(seed) & 3;
            end else begin
                // ready on about one cycle in four
                arready <= ($random(seed) & 3) == 0;
            end
        end else if (rvalid) begin
            if (rready) begin
                rvalid     <= 1'b0;
                data_phase <= 1'b0;
            end
        end else if (delay == 0) begin
            rvalid <= 1'b1;
            rdata  <= block_beat(addr_q);
            rresp  <= (addr_q == ERR_ADDR) ? 2'b10 : RESP_OKAY;
        end else begin
            delay <= delay - 1;
        end
    end

endmodule

`default_nettype wire

//--- tb/icache_tb.sv
/*
 * instruction cache testbench
 * miss, hit, replacement, error and flush sequences checked by assertions
 */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam int    WAIT_LIMIT = 200;
    localparam addr_t ERR_ADDR   = 32'h0000_3000;
    // three blocks that all map to set 1
    localparam addr_t BLK_A = 32'h0000_1008;
    localparam addr_t BLK_B = 32'h0000_1808;
    localparam addr_t BLK_C = 32'h0000_2008;

    logic  clk = 1'b0;
    logic  rst;
    addr_t pc;
    logic  stall;
    logic  flush;
    logic  arvalid;
    addr_t araddr;
    logic  arready;
    logic  rvalid;
    logic  rready;
    beat_t rdata;
    resp_t rresp;
    inst_t inst;
    logic  inst_valid;
    logic  error;

    // expectations of the fetch in flight
    logic  fetch_active;
    logic  expect_hit;
    logic  expect_miss;
    inst_t exp_inst;
    addr_t exp_addr;
    logic  exp_err;
    inst_t held_inst;
    int    ar_count;
    int    ar_start;
    int    fetches;
    int    errors = 0;
    logic  timed_out;

    always #2 clk = ~clk;

    icache_top #(
        .SET_BITS (8)
    ) icache_top_i (
        .clk (clk), .rst (rst), .pc (pc), .stall (stall), .flush (flush),
        .arvalid (arvalid), .araddr (araddr), .arready (arready),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
        .inst (inst), .inst_valid (inst_valid), .error (error)
    );

    axi_mem_model #(
        .ERR_ADDR (ERR_ADDR),
        .SEED     (81942)
    ) mem_i (
        .clk (clk), .rst (rst), .arvalid (arvalid), .araddr (araddr),
        .arready (arready), .rvalid (rvalid), .rready (rready),
        .rdata (rdata), .rresp (rresp)
    );

    // rule word of the block holding addr, bit 2 picks the half
    function automatic inst_t rule_word(input addr_t addr);
        inst_t lo;
        lo = (addr & ~32'h7) ^ 32'h5A5A_5A5A;
        return addr[2] ? ~lo : lo;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            ar_count <= 0;
        end else if (arvalid && arready) begin
            ar_count <= ar_count + 1;
        end
    end

    // ========================================
    // checks
    // ========================================
    a_reset_state : assert property (
        @(posedge clk) $fell(rst) |->
            !arvalid && !rready && inst_valid && inst == NOP_INST && !error
    ) else begin
        errors++;
        $display("FAILED reset state: arvalid=%h rready=%h inst_valid=%h inst=%h error=%h",
                 $sampled(arvalid), $sampled(rready), $sampled(inst_valid), $sampled(inst),
                 $sampled(error));
    end

    a_araddr_aligned : assert property (
        @(posedge clk) disable iff (rst) $rose(arvalid) |-> araddr == (exp_addr & ~32'h7)
    ) else begin
        errors++;
        $display("FAILED araddr: got %h expected %h", $sampled(araddr), exp_addr & ~32'h7);
    end

    a_arvalid_held : assert property (
        @(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid
    ) else begin
        errors++;
        $display("arvalid dropped before the request was accepted");
    end

    a_hit_no_bus : assert property (
        @(posedge clk) disable iff (rst) expect_hit |-> !arvalid
    ) else begin
        errors++;
        $display("bus read issued for a fetch that should hit");
    end

    a_hit_gap : assert property (
        @(posedge clk) disable iff (rst) expect_hit && $fell(inst_valid) |=> inst_valid
    ) else begin
        errors++;
        $display("inst_valid stayed low for more than one cycle on a hit");
    end

    a_miss_read : assert property (
        @(posedge clk) disable iff (rst) expect_miss && $rose(inst_valid) |-> ar_count != ar_start
    ) else begin
        errors++;
        $display("no bus read for a fetch that should miss");
    end

    a_inst_value : assert property (
        @(posedge clk) disable iff (rst) fetch_active && $rose(inst_valid) |-> inst == exp_inst
    ) else begin
        errors++;
        $display("FAILED inst: got %h expected %h", $sampled(inst), exp_inst);
    end

    a_error_value : assert property (
        @(posedge clk) disable iff (rst) fetch_active && $rose(inst_valid) |-> error == exp_err
    ) else begin
        errors++;
        $display("FAILED error: got %h expected %h", $sampled(error), exp_err);
    end

    a_flush_nop : assert property (
        @(posedge clk) disable iff (rst) flush && !stall |=> inst_valid && inst == NOP_INST
    ) else begin
        errors++;
        $display("FAILED inst after flush: got %h expected %h, inst_valid %h",
                 $sampled(inst), NOP_INST, $sampled(inst_valid));
    end

    a_flush_stalled : assert property (
        @(posedge clk) disable iff (rst) flush && stall |=> inst == held_inst
    ) else begin
        errors++;
        $display("FAILED inst after stalled flush: got %h expected %h", $sampled(inst), held_inst);
    end

    // ========================================
    // stimulus
    // ========================================
    task automatic wait_valid(input logic level, input string what);
        int n;
        n = 0;
        while (!timed_out && inst_valid != level) begin
            if (n == WAIT_LIMIT) begin
                $display("timeout: inst_valid stuck at %0b during %s", inst_valid, what);
                timed_out = 1'b1;
                errors++;
            end else begin
                @(posedge clk);
                n++;
            end
        end
    endtask

    task automatic fetch(input addr_t addr, input logic want_hit);
        if (!timed_out) begin
            @(posedge clk);
            pc           <= addr;
            stall        <= 1'b0;
            exp_addr     <= addr;
            exp_inst     <= rule_word(addr);
            expect_hit   <= want_hit;
            expect_miss  <= !want_hit;
            ar_start     <= ar_count;
            fetch_active <= 1'b1;
            // one lookup only, the cache holds the fetch from here
            @(posedge clk);
            stall <= 1'b1;
            wait_valid(1'b0, "fetch start");
            wait_valid(1'b1, "fetch end");
            fetch_active <= 1'b0;
            expect_hit   <= 1'b0;
            expect_miss  <= 1'b0;
            fetches++;
        end
    endtask

    task automatic flush_pulse(input logic with_stall);
        @(posedge clk);
        flush     <= 1'b1;
        stall     <= with_stall;
        held_inst <= inst;
        @(posedge clk);
        flush <= 1'b0;
        stall <= 1'b1;
        @(posedge clk);
    endtask

    initial begin
        rst          = 1'b1;
        pc           = '0;
        stall        = 1'b1;
        flush        = 1'b0;
        fetch_active = 1'b0;
        expect_hit   = 1'b0;
        expect_miss  = 1'b0;
        exp_inst     = NOP_INST;
        exp_addr     = '0;
        exp_err      = 1'b0;
        held_inst    = NOP_INST;
        ar_start     = 0;
        fetches      = 0;
        timed_out    = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        // cold miss on the upper half, then the lower half hits
        fetch(32'h0000_0104, 1'b0);
        fetch(32'h0000_0100, 1'b1);

        // victim way of set 1 alternates from way 0
        fetch(BLK_A, 1'b0);
        fetch(BLK_B, 1'b0);
        fetch(BLK_A + 4, 1'b1);
        fetch(BLK_B + 4, 1'b1);
        fetch(BLK_C, 1'b0);
        fetch(BLK_B, 1'b1);
        fetch(BLK_A + 4, 1'b0);
        fetch(BLK_C + 4, 1'b1);

        // error set by a bad response, kept on a hit, cleared by a good refill
        exp_err <= 1'b1;
        fetch(ERR_ADDR + 4, 1'b0);
        fetch(ERR_ADDR, 1'b1);
        exp_err <= 1'b0;
        fetch(32'h0000_4010, 1'b0);

        flush_pulse(1'b1);
        flush_pulse(1'b0);
        fetch(32'h0000_4014, 1'b1);

        repeat (4) @(posedge clk);
        $display("summary: %0d fetches, %0d bus reads, %0d errors", fetches, ar_count, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hw/icache_pkg.sv
hw/icache_tag_store.sv
hw/icache_data_store.sv
hw/icache_refill.sv
hw/icache_fetch_out.sv
hw/icache_top.sv
tb/axi_mem_model.sv
tb/icache_tb.sv

//--- run.sh
#!/bin/sh
# build the cache testbench with verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module icache_tb -o icache_sim -f src.f \
    || { echo "build failed"; exit 1; }
./obj_dir/icache_sim > sim.log 2>&1
status=$?
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
[ "$status" -eq 0 ] || { echo "simulation stopped early"; exit 1; }
exit 0
